// ==== compile.f ====
design/ahb_axi_pkg.sv
design/ahb_addr_phase.sv
design/ahb_bus_fsm.sv
design/axi_cmd_buf.sv
design/ahb_to_axi_lite.sv
sim/axi_lite_mem.sv
sim/tb_ahb_to_axi_lite.sv

// ==== design/ahb_addr_phase.sv ====
// Captures each accepted AHB address phase and checks it before the FSM sends it to AXI
module ahb_addr_phase #(
   parameter ahb_axi_pkg::addr_t REGION_BASE = 32'h0000_0000,
   parameter ahb_axi_pkg::addr_t REGION_SIZE = 32'h0000_1000
) (
   input  logic                     bus_clk,
   input  logic                     rst,
   input  ahb_axi_pkg::ahb_req_t    ahb,
   input  logic                     accept,
   output ahb_axi_pkg::addr_phase_t phase,
   output logic                     access_err
);
   import ahb_axi_pkg::*;

   addr_t offset;       // Address relative to the region base
   logic  in_region;
   logic  size_err;     // Region write narrower than a word
   logic  align_err;
   strb_t strb_in;      // Lanes touched by the incoming transfer

   // ****************************************
   // Checks on the incoming address phase
   // ****************************************
   // Wraps to a large value below the base, so one compare covers both ends
   assign offset    = ahb.haddr - REGION_BASE;
   assign in_region = (offset < REGION_SIZE);
   assign size_err  = ahb.hwrite & (ahb.hsize < 3'd2);   // Byte or halfword write

   always_comb begin
      case (ahb.hsize)
         3'd0:    align_err = 1'b0;                // Byte is always aligned
         3'd1:    align_err = ahb.haddr[0];
         3'd2:    align_err = |ahb.haddr[1:0];
         3'd3:    align_err = |ahb.haddr[2:0];
         default: align_err = 1'b1;                // Wider than the bus
      endcase
   end

   // Byte lanes from size and low address bits
   always_comb begin
      case (ahb.hsize)
         3'd0:    strb_in = 8'h01 << ahb.haddr[2:0];
         3'd1:    strb_in = 8'h03 << ahb.haddr[2:0];
         3'd2:    strb_in = 8'h0f << ahb.haddr[2:0];
         3'd3:    strb_in = 8'hff;                 // Full doubleword
         default: strb_in = '0;
      endcase
   end

   // ****************************************
   // Phase registers
   // ****************************************
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         phase.valid <= 1'b0;
         access_err  <= 1'b0;
      end else if (accept) begin
         phase.valid <= 1'b1;
         access_err  <= ~in_region | size_err | align_err;
      end else if (ahb.hreadyin) begin
         // Bus moved on with no transfer for this slave
         phase.valid <= 1'b0;
         access_err  <= 1'b0;
      end
      if (accept) begin                             // Payload, loaded on accept only
         phase.addr  <= ahb.haddr;
         phase.size  <= ahb.hsize;
         phase.write <= ahb.hwrite;
         phase.strb  <= strb_in;
      end
   end

   // Masters on this bus never issue transfers wider than a doubleword
   a_size_max: assert property (@(posedge bus_clk) disable iff (rst)
      phase.valid |-> (phase.size <= 3'd3));

endmodule

// ==== design/ahb_axi_pkg.sv ====
// Shared widths, vector types, enums and bus structs that every bridge block imports
package ahb_axi_pkg;

   // ****************************************
   // Widths
   // ****************************************
   localparam int ADDR_W = 32;            // Byte address
   localparam int DATA_W = 64;            // One bus beat
   localparam int STRB_W = DATA_W / 8;    // Byte lanes per beat

   typedef logic [ADDR_W-1:0] addr_t;     // AHB or AXI address
   typedef logic [DATA_W-1:0] data_t;     // Data beat
   typedef logic [STRB_W-1:0] strb_t;     // Write byte strobes
   typedef logic [2:0]        hsize_t;    // AHB transfer size as log2 of bytes
   typedef logic [1:0]        resp_t;     // AXI response with 2'b00 for OKAY

   // ****************************************
   // Encodings
   // ****************************************
   typedef enum logic [1:0] {
      IDLE_T   = 2'b00,
      BUSY_T   = 2'b01,
      NONSEQ_T = 2'b10,
      SEQ_T    = 2'b11
   } htrans_t;

   typedef enum logic [1:0] {
      BUS_IDLE = 2'b00,    // No data phase in progress
      BUS_WR   = 2'b01,    // Write data phase
      BUS_RD   = 2'b10,    // Read data phase before the command goes out
      BUS_PEND = 2'b11     // Read sent and waiting on rvalid
   } bus_state_t;

   // ****************************************
   // Port structs
   // ****************************************
   typedef struct packed {
      addr_t   haddr;
      htrans_t htrans;
      logic    hwrite;
      hsize_t  hsize;
      data_t   hwdata;
      logic    hsel;
      logic    hreadyin;
   } ahb_req_t;

   typedef struct packed {
      data_t hrdata;
      logic  hreadyout;
      logic  hresp;
   } ahb_rsp_t;

   typedef struct packed {
      addr_t  addr;
      hsize_t size;
      logic   write;
      strb_t  strb;
      logic   valid;       // Real transfer captured
   } addr_phase_t;

   typedef struct packed {
      logic  awvalid;
      addr_t awaddr;
      logic  wvalid;
      data_t wdata;
      strb_t wstrb;
      logic  bready;
      logic  arvalid;
      addr_t araddr;
      logic  rready;
   } axi_req_t;

   typedef struct packed {
      logic  awready;
      logic  wready;
      logic  bvalid;
      resp_t bresp;
      logic  arready;
      logic  rvalid;
      data_t rdata;
      resp_t rresp;
   } axi_rsp_t;

endpackage

// ==== design/ahb_bus_fsm.sv ====
// Bus state machine of the bridge that paces hreadyout and hresp and returns read data
module ahb_bus_fsm (
   input  logic                     bus_clk,
   input  logic                     rst,
   input  ahb_axi_pkg::ahb_req_t    ahb,
   input  ahb_axi_pkg::addr_phase_t phase,
   input  logic                     access_err,
   input  logic                     cmd_full,
   input  logic                     cmd_write,
   input  ahb_axi_pkg::axi_rsp_t    axi_r,
   output logic                     accept,
   output logic                     cmd_load,
   output logic                     cmd_drop,
   output ahb_axi_pkg::ahb_rsp_t    ahb_rsp
);
   import ahb_axi_pkg::*;

   bus_state_t state;
   bus_state_t state_nxt;
   logic       hreadyout;
   logic       hresp;
   logic       hready;       // Bus-wide ready, address phase sampling point
   logic       addr_req;     // Master presents a real transfer to this slave
   logic       phase_err;    // Current data phase failed its checks
   logic       err_first;    // First error cycle, hreadyout low
   logic       err_second;   // Second error cycle, hreadyout high
   logic       rd_load;      // Read data returning this cycle
   logic       rd_err_q;     // Returned read was not OKAY
   data_t      rdata_q;

   assign addr_req  = ahb.hsel & ((ahb.htrans == NONSEQ_T) | (ahb.htrans == SEQ_T));
   assign hready    = hreadyout & ahb.hreadyin;
   assign accept    = hready & addr_req;

   // Errors are decided in the data phase, before any command is sent
   assign phase_err = phase.valid & access_err & ((state == BUS_WR) | (state == BUS_RD));
   assign err_first = phase_err | rd_err_q;
   assign cmd_drop  = phase_err;             // Errored phase never loads
   assign hresp     = err_first | err_second;

   // ****************************************
   // Next state and command load
   // ****************************************
   always_comb begin
      state_nxt = state;
      cmd_load  = 1'b0;
      rd_load   = 1'b0;
      case (state)
         BUS_IDLE: begin
            if (accept) begin
               state_nxt = ahb.hwrite ? BUS_WR : BUS_RD;
            end
         end
         BUS_WR: begin
            if (phase_err) begin
               state_nxt = BUS_IDLE;
            end else if (!cmd_full) begin
               cmd_load = 1'b1;               // hwdata is on the bus now
               if (accept) begin              // Pipelined next address phase
                  state_nxt = ahb.hwrite ? BUS_WR : BUS_RD;
               end else begin
                  state_nxt = BUS_IDLE;
               end
            end
         end
         BUS_RD: begin
            if (phase_err) begin
               state_nxt = BUS_IDLE;
            end else if (!cmd_full) begin     // Wait out an older write
               cmd_load  = 1'b1;
               state_nxt = BUS_PEND;
            end
         end
         default: begin                       // BUS_PEND
            if (axi_r.rvalid & ~cmd_write) begin
               rd_load   = 1'b1;
               state_nxt = BUS_IDLE;          // Data shows next cycle
            end
         end
      endcase
   end

   // ****************************************
   // AHB response
   // ****************************************
   always_comb begin
      if (err_second) begin
         hreadyout = 1'b1;                    // Error ends, master may move on
      end else if (err_first) begin
         hreadyout = 1'b0;
      end else begin
         case (state)
            BUS_IDLE: hreadyout = 1'b1;
            BUS_WR:   hreadyout = ~cmd_full;  // Back-pressure on a busy buffer
            default:  hreadyout = 1'b0;       // Reads wait for the AXI return
         endcase
      end
   end

   assign ahb_rsp = '{hrdata: rdata_q, hreadyout: hreadyout, hresp: hresp};

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state      <= BUS_IDLE;
         err_second <= 1'b0;
         rd_err_q   <= 1'b0;
      end else begin
         state      <= state_nxt;
         err_second <= err_first;
         rd_err_q   <= rd_load & (axi_r.rresp != 2'b00);   // One-cycle flag
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rd_load) begin
         rdata_q <= axi_r.rdata;
      end
   end

   // AHB two-cycle error response
   a_err_two_cycle: assert property (@(posedge bus_clk) disable iff (rst)
      (hresp && hreadyout) |-> $past(hresp && !hreadyout));

endmodule

// ==== design/ahb_to_axi_lite.sv ====
// Top level of the AHB-Lite slave to AXI4-Lite master bridge, set the region through its parameters
module ahb_to_axi_lite #(
   parameter ahb_axi_pkg::addr_t REGION_BASE = 32'h0000_0000,   // Start of the allowed region
   parameter ahb_axi_pkg::addr_t REGION_SIZE = 32'h0000_1000    // Region length in bytes
) (
   input  logic                  bus_clk,
   input  logic                  rst,
   input  ahb_axi_pkg::ahb_req_t ahb,
   output ahb_axi_pkg::ahb_rsp_t ahb_rsp,
   output ahb_axi_pkg::axi_req_t axi_req,
   input  ahb_axi_pkg::axi_rsp_t axi_rsp
);
   import ahb_axi_pkg::*;

   addr_phase_t phase;       // Registered address phase
   logic        accept;      // Address phase taken this cycle
   logic        access_err;  // Registered check result
   logic        cmd_load;
   logic        cmd_drop;
   logic        cmd_full;
   logic        cmd_write;

   // ****************************************
   // Address phase and checks
   // ****************************************
   ahb_addr_phase #(
      .REGION_BASE (REGION_BASE),
      .REGION_SIZE (REGION_SIZE)
   ) addr_phase_i (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .ahb        (ahb),
      .accept     (accept),
      .phase      (phase),
      .access_err (access_err)
   );

   // Bus FSM and AHB response
   ahb_bus_fsm bus_fsm_i (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .ahb        (ahb),
      .phase      (phase),
      .access_err (access_err),
      .cmd_full   (cmd_full),
      .cmd_write  (cmd_write),
      .axi_r      (axi_rsp),
      .accept     (accept),
      .cmd_load   (cmd_load),
      .cmd_drop   (cmd_drop),
      .ahb_rsp    (ahb_rsp)
   );

   // Command buffer, write data taken straight from the data phase
   axi_cmd_buf cmd_buf_i (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .cmd_load  (cmd_load),
      .cmd_drop  (cmd_drop),
      .phase     (phase),
      .wdata     (ahb.hwdata),
      .axi_rsp   (axi_rsp),
      .axi_req   (axi_req),
      .cmd_full  (cmd_full),
      .cmd_write (cmd_write)
   );

endmodule

// ==== design/axi_cmd_buf.sv ====
// One-entry command buffer of the bridge that drives the AXI4-Lite write and read channels
module axi_cmd_buf (
   input  logic                     bus_clk,
   input  logic                     rst,
   input  logic                     cmd_load,
   input  logic                     cmd_drop,
   input  ahb_axi_pkg::addr_phase_t phase,
   input  ahb_axi_pkg::data_t       wdata,
   input  ahb_axi_pkg::axi_rsp_t    axi_rsp,
   output ahb_axi_pkg::axi_req_t    axi_req,
   output logic                     cmd_full,
   output logic                     cmd_write
);
   import ahb_axi_pkg::*;

   addr_t cmd_addr;
   data_t cmd_wdata;
   strb_t cmd_strb;
   logic  cmd_vld;      // Entry holds a command
   logic  aw_done;      // Write address already taken
   logic  w_done;       // Write data already taken
   logic  awvalid;
   logic  wvalid;
   logic  arvalid;
   logic  aw_hs;
   logic  w_hs;
   logic  ar_hs;
   logic  retire;       // Last handshake of the command is this cycle
   logic  load_en;

   // ****************************************
   // Channel valids and handshakes
   // ****************************************
   assign awvalid = cmd_vld & cmd_write & ~aw_done;
   assign wvalid  = cmd_vld & cmd_write & ~w_done;
   assign arvalid = cmd_vld & ~cmd_write;

   assign aw_hs   = awvalid & axi_rsp.awready;
   assign w_hs    = wvalid  & axi_rsp.wready;
   assign ar_hs   = arvalid & axi_rsp.arready;

   // Write retires when both channels are through, in either order
   assign retire   = cmd_vld & (cmd_write ? ((aw_done | aw_hs) & (w_done | w_hs)) : ar_hs);
   assign cmd_full = cmd_vld & ~retire;     // Frees in the retiring cycle
   assign load_en  = cmd_load & ~cmd_drop;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         cmd_vld   <= 1'b0;
         cmd_write <= 1'b0;
         aw_done   <= 1'b0;
         w_done    <= 1'b0;
      end else if (load_en) begin           // May overlap a retire
         cmd_vld   <= 1'b1;
         cmd_write <= phase.write;
         aw_done   <= 1'b0;
         w_done    <= 1'b0;
      end else if (retire) begin
         cmd_vld   <= 1'b0;
         aw_done   <= 1'b0;
         w_done    <= 1'b0;
      end else begin
         aw_done   <= aw_done | aw_hs;
         w_done    <= w_done | w_hs;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (load_en) begin
         cmd_addr  <= phase.addr;
         cmd_wdata <= wdata;
         cmd_strb  <= phase.strb;
      end
   end

   // Responses are always taken, write response content is ignored
   assign axi_req = '{awvalid: awvalid, awaddr: cmd_addr, wvalid: wvalid, wdata: cmd_wdata,
                      wstrb: cmd_strb, bready: 1'b1, arvalid: arvalid, araddr: cmd_addr,
                      rready: 1'b1};

   // Valid and payload hold until the handshake, across FSM loads
   a_aw_stable: assert property (@(posedge bus_clk) disable iff (rst)
      (awvalid && !axi_rsp.awready) |=> (awvalid && $stable(cmd_addr)));
   a_w_stable: assert property (@(posedge bus_clk) disable iff (rst)
      (wvalid && !axi_rsp.wready) |=> (wvalid && $stable(cmd_wdata) && $stable(cmd_strb)));
   a_ar_stable: assert property (@(posedge bus_clk) disable iff (rst)
      (arvalid && !axi_rsp.arready) |=> (arvalid && $stable(cmd_addr)));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module tb_ahb_to_axi_lite -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

if echo "$output" | grep -qx "All tests passed!"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== sim/axi_lite_mem.sv ====
// AXI4-Lite slave memory for the bridge testbench with random ready/valid delays and read error injection
module axi_lite_mem #(
   parameter int                 MEM_DEPTH = 512,           // Doublewords held
   parameter ahb_axi_pkg::addr_t ERR_ADDR  = 32'h0000_0f00, // Reads here answer SLVERR
   parameter int                 SEED      = 32'hcd0b
) (
   input  logic                  bus_clk,
   input  logic                  rst,
   input  ahb_axi_pkg::axi_req_t axi_req,
   output ahb_axi_pkg::axi_rsp_t axi_rsp
);
   timeunit 1ns;
   timeprecision 1ps;
   import ahb_axi_pkg::*;

   logic [7:0] mem [MEM_DEPTH*8];   // Byte storage, lane order inside a beat
   int         seed;
   addr_t      aw_addr;             // Captured write address
   data_t      w_data;
   strb_t      w_strb;
   logic       aw_got;
   logic       w_got;
   addr_t      rd_addr;
   logic       rd_busy;             // Read accepted, response not yet taken
   int         rd_wait;             // Cycles left before rvalid
   int         base;
   data_t      rd_beat;

   initial begin
      seed = SEED;
      for (int i = 0; i < MEM_DEPTH * 8; i++) begin
         mem[i] = 8'h00;
      end
   end

   // ****************************************
   // Channel handling
   // ****************************************
   always @(posedge bus_clk) begin
      if (rst) begin
         axi_rsp <= '0;
         aw_got  = 1'b0;
         w_got   = 1'b0;
         rd_busy = 1'b0;
         rd_wait = 0;
      end else begin
         if (axi_req.awvalid && axi_rsp.awready) begin
            aw_addr = axi_req.awaddr;
            aw_got  = 1'b1;
         end
         if (axi_req.wvalid && axi_rsp.wready) begin
            w_data = axi_req.wdata;
            w_strb = axi_req.wstrb;
            w_got  = 1'b1;
         end
         if (aw_got && w_got) begin              // Both halves in, commit strobed lanes
            base = ((aw_addr >> 3) % MEM_DEPTH) * 8;
            for (int i = 0; i < 8; i++) begin
               if (w_strb[i]) mem[base + i] = w_data[8*i +: 8];
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
            axi_rsp.bvalid <= 1'b1;
            axi_rsp.bresp  <= 2'b00;
         end else if (axi_rsp.bvalid && axi_req.bready) begin
            axi_rsp.bvalid <= 1'b0;
         end
         axi_rsp.awready <= !aw_got && (($random(seed) & 1) != 0);   // Random stalls
         axi_rsp.wready  <= !w_got && (($random(seed) & 1) != 0);

         // Read side
         if (axi_rsp.rvalid && axi_req.rready) begin
            axi_rsp.rvalid <= 1'b0;
            rd_busy = 1'b0;
         end else if (axi_req.arvalid && axi_rsp.arready && !rd_busy) begin
            rd_addr = axi_req.araddr;
            rd_busy = 1'b1;
            rd_wait = $random(seed) & 3;         // Response delay 0 to 3 cycles
         end else if (rd_busy && !axi_rsp.rvalid) begin
            if (rd_wait == 0) begin
               base = ((rd_addr >> 3) % MEM_DEPTH) * 8;
               for (int i = 0; i < 8; i++) begin
                  rd_beat[8*i +: 8] = mem[base + i];
               end
               axi_rsp.rdata  <= rd_beat;
               axi_rsp.rresp  <= (rd_addr == ERR_ADDR) ? 2'b10 : 2'b00;
               axi_rsp.rvalid <= 1'b1;
            end else begin
               rd_wait = rd_wait - 1;
            end
         end
         axi_rsp.arready <= !rd_busy && (($random(seed) & 1) != 0);
      end
   end

endmodule

// ==== sim/bridge_golden.txt ====
# op addr size(log2 bytes) wdata rdata err, all hex
# rdata is the full beat, checked only on the lanes the read touches
W 00000000 3 1122334455667788 0000000000000000 0
W 00000008 2 00000000aabbccdd 0000000000000000 0
W 0000000c 2 0badf00d00000000 0000000000000000 0
R 00000000 3 0000000000000000 1122334455667788 0
R 0000000d 0 0000000000000000 0badf00daabbccdd 0
R 0000000a 1 0000000000000000 0badf00daabbccdd 0
R 00000004 2 0000000000000000 1122334455667788 0
W 00000001 0 000000000000ff00 0000000000000000 1
W 00000006 2 ffffffff00000000 0000000000000000 1
R 00000002 2 0000000000000000 0000000000000000 1
W 00000009 3 ffffffffffffffff 0000000000000000 1
R 00000000 3 0000000000000000 1122334455667788 0
R 00000008 3 0000000000000000 0badf00daabbccdd 0
W 00001000 3 5555555555555555 0000000000000000 1
R 00002000 2 0000000000000000 0000000000000000 1
W 00000f00 3 cafef00dcafef00d 0000000000000000 0
R 00000f00 3 0000000000000000 0000000000000000 1
R 00000000 3 0000000000000000 1122334455667788 0
W 00000010 3 0123456789abcdef 0000000000000000 0
R 00000010 3 0000000000000000 0123456789abcdef 0
W 00000018 2 00000000deadbeef 0000000000000000 0
W 0000001c 2 feedface00000000 0000000000000000 0
R 00000018 3 0000000000000000 feedfacedeadbeef 0
R 0000001e 1 0000000000000000 feedfacedeadbeef 0

// ==== sim/tb_ahb_to_axi_lite.sv ====
// Bridge testbench that replays the golden transaction file over AHB against an AXI memory model
module tb_ahb_to_axi_lite;
   timeunit 1ns;
   timeprecision 1ps;
   import ahb_axi_pkg::*;

   localparam int    MEM_DEPTH = 512;
   localparam addr_t ERR_ADDR  = 32'h0000_0f00;
   localparam int    TIMEOUT   = 200;            // Cycles per wait on hreadyout
   localparam int    SEED      = 32'hcd0b;

   logic     bus_clk;
   logic     rst;
   ahb_req_t ahb_drv;      // Master side with hreadyin filled in below
   ahb_req_t ahb_req;
   ahb_rsp_t ahb_rsp;
   axi_req_t axi_req;
   axi_rsp_t axi_rsp;
   int       data_errs;
   int       resp_errs;
   int       idle_errs;
   int       other_errs;
   logic     timed_out;

   // Single slave on the bus, so hreadyin follows its own hreadyout
   always_comb begin
      ahb_req          = ahb_drv;
      ahb_req.hreadyin = ahb_rsp.hreadyout;
   end

   ahb_to_axi_lite #(
      .REGION_BASE (32'h0000_0000),
      .REGION_SIZE (32'h0000_1000)
   ) ahb_to_axi_lite_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .ahb     (ahb_req),
      .ahb_rsp (ahb_rsp),
      .axi_req (axi_req),
      .axi_rsp (axi_rsp)
   );

   axi_lite_mem #(.MEM_DEPTH(MEM_DEPTH), .ERR_ADDR(ERR_ADDR), .SEED(SEED)) mem_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .axi_req (axi_req),
      .axi_rsp (axi_rsp)
   );

   initial bus_clk = 1'b0;
   always #10 bus_clk = ~bus_clk;

   // ****************************************
   // Compare tasks
   // ****************************************
   task automatic check_data(input string name, input data_t got, input data_t exp,
                             input data_t mask);
      if ((got & mask) !== (exp & mask)) begin
         $display("Mismatch %s: got %h expected %h lanes %h", name, got, exp, mask);
         data_errs++;
      end
   endtask

   task automatic check_resp(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         resp_errs++;
      end
   endtask

   task automatic check_idle(input ahb_rsp_t rsp, input axi_req_t req);
      if (rsp.hreadyout !== 1'b1 || rsp.hresp !== 1'b0) begin
         $display("Mismatch hreadyout/hresp: got %h/%h expected 1/0", rsp.hreadyout, rsp.hresp);
         idle_errs++;
      end
      if ({req.awvalid, req.wvalid, req.arvalid} !== 3'b000) begin
         $display("Mismatch awvalid/wvalid/arvalid: got %h expected 0",
                  {req.awvalid, req.wvalid, req.arvalid});
         idle_errs++;
      end
   endtask

   // Lanes a transfer touches by size and low address bits
   function automatic data_t lane_mask(input hsize_t size, input addr_t addr);
      data_t mask;
      int    lo;
      mask = '0;
      lo   = int'(addr[2:0]);
      for (int i = 0; i < 8; i++) begin
         if (i >= lo && i < lo + (1 << size)) begin
            mask[8*i +: 8] = 8'hff;
         end
      end
      return mask;
   endfunction

   // Waits on falling edges for hreadyout and keeps hresp of the last wait state
   task automatic wait_hreadyout(output logic ok, output logic wait_resp);
      int cnt;
      cnt       = 0;
      wait_resp = 1'b0;
      @(negedge bus_clk);
      while (!ahb_rsp.hreadyout && cnt < TIMEOUT) begin
         wait_resp = ahb_rsp.hresp;        // First error cycle shows up here
         cnt++;
         @(negedge bus_clk);
      end
      ok = ahb_rsp.hreadyout;
   endtask

   // One non-pipelined AHB transfer started right after a rising edge
   task automatic do_transfer(input logic write, input addr_t addr, input hsize_t size,
                              input data_t wdata, output data_t rdata, output logic err,
                              output logic err_first, output logic ok);
      logic addr_resp;
      ahb_drv.hsel   <= 1'b1;
      ahb_drv.htrans <= NONSEQ_T;
      ahb_drv.haddr  <= addr;
      ahb_drv.hwrite <= write;
      ahb_drv.hsize  <= size;
      wait_hreadyout(ok, addr_resp);       // Address taken at the next edge
      if (!ok) return;
      @(posedge bus_clk);
      ahb_drv.hsel   <= 1'b0;
      ahb_drv.htrans <= IDLE_T;
      ahb_drv.hwdata <= wdata;
      wait_hreadyout(ok, err_first);       // Data phase ends here
      if (!ok) return;
      rdata = ahb_rsp.hrdata;
      err   = ahb_rsp.hresp;
      @(posedge bus_clk);
   endtask

   // ****************************************
   // Golden file replay
   // ****************************************
   task automatic run_golden();
      int     fd;
      int     n;
      int     line_no;
      string  line;
      string  op;
      addr_t  addr;
      hsize_t size;
      data_t  wdata;
      data_t  exp_rdata;
      logic   exp_err;
      data_t  rdata;
      logic   err;
      logic   err_first;
      logic   ok;
      line_no = 0;
      fd = $fopen("sim/bridge_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden transaction file");
         other_errs++;
         return;
      end
      while (!$feof(fd) && !timed_out) begin
         line = "";
         n = $fgets(line, fd);
         line_no++;
         if (line.len() < 2 || line[0] == 8'h23) begin   // Blank or comment
            continue;
         end
         n = $sscanf(line, "%s %h %h %h %h %h", op, addr, size, wdata, exp_rdata, exp_err);
         if (n != 6) begin
            $display("Golden file line %0d could not be parsed", line_no);
            other_errs++;
            continue;
         end
         do_transfer(op == "W", addr, size, wdata, rdata, err, err_first, ok);
         if (!ok) begin
            $display("Timed out waiting for hreadyout on golden line %0d", line_no);
            other_errs++;
            timed_out = 1'b1;
         end else begin
            // Error takes a low-hreadyout cycle and then a high one
            check_resp($sformatf("hresp first cycle line %0d", line_no), err_first, exp_err);
            check_resp($sformatf("hresp line %0d", line_no), err, exp_err);
            if (op == "R" && !exp_err) begin
               check_data($sformatf("hrdata line %0d", line_no), rdata, exp_rdata,
                          lane_mask(size, addr));
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin
      data_errs  = 0;
      resp_errs  = 0;
      idle_errs  = 0;
      other_errs = 0;
      timed_out  = 1'b0;
      ahb_drv    = '0;
      rst        = 1'b1;
      repeat (4) @(posedge bus_clk);
      rst <= 1'b0;
      @(negedge bus_clk);
      check_idle(ahb_rsp, axi_req);       // Post-reset outputs
      @(posedge bus_clk);
      run_golden();
      $display("Error count: data %0d, response %0d, idle %0d, other %0d",
               data_errs, resp_errs, idle_errs, other_errs);
      if (data_errs + resp_errs + idle_errs + other_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
